/* Makefile */
# Verilator build and run of the flow BIST testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module flow_bist_tb -f sim.f
	./obj_dir/Vflow_bist_tb 2>&1 | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG) || ! grep -q "ALL CHECKS PASSED" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* rtl/flow_bist_pkg.sv */
package flow_bist_pkg;

  // Bus word layout
  localparam int SEQ_W   = 12;                      // Sequence number width
  localparam int ID_W    = 1;                       // Source id width
  localparam int WORD_W  = 16;                      // Full bus word
  localparam int PAD_W   = WORD_W - ID_W - SEQ_W;   // Zero bits between id and sequence

  localparam int NUM_SRC = 2;                       // Pattern sources sharing the bus
  localparam int LFSR_W  = 16;                      // Rate gate LFSR width
  localparam int RATE_W  = 8;                       // Rate threshold width
  localparam int ERR_W   = 16;                      // Saturating error counter width

  typedef logic [SEQ_W-1:0]  seq_t;
  typedef logic [ID_W-1:0]   src_id_t;
  typedef logic [WORD_W-1:0] flow_word_t;           // {id, pad, seq}
  typedef logic [RATE_W-1:0] rate_t;                // Assert chance is rate/256 per idle cycle
  typedef logic [ERR_W-1:0]  err_count_t;
  typedef logic [LFSR_W-1:0] lfsr_t;

  // Source FSM
  typedef enum logic [1:0] {
    SRC_IDLE,   // Waiting for start
    SRC_RUN,    // Sending words
    SRC_DONE    // All NUM_VALUES words sent
  } src_state_t;

  // Build a bus word from id and sequence
  function automatic flow_word_t make_word(input src_id_t id, input seq_t seq);
    return {id, {PAD_W{1'b0}}, seq};
  endfunction

  // Sender id sits in the top bit(s)
  function automatic src_id_t word_id(input flow_word_t word);
    return word[WORD_W-1 -: ID_W];
  endfunction

endpackage

/* rtl/flow_bist_top.sv */
`timescale 1ns/1ps

module flow_bist_top #(
  parameter int NUM_VALUES = 64,  // Words per source, up to 4095
  parameter int INIT_DELAY = 10
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      start,         // Pulse
  input  flow_bist_pkg::rate_t      src_rate,      // Shared by both sources
  input  flow_bist_pkg::rate_t      sink_rate,
  input  logic                      inject_fault,  // Pulse, goes to source 0 only
  output logic                      done,
  output logic                      error,
  output flow_bist_pkg::err_count_t err_count,
  output flow_bist_pkg::flow_word_t bad_word
);
  import flow_bist_pkg::*;

  logic [1:0] src_valid;
  logic [1:0] src_ready;
  flow_word_t src_data0;
  flow_word_t src_data1;
  logic       bus_valid;
  logic       bus_ready;
  flow_word_t bus_data;

  flow_pattern_source #(
    .SRC_ID    (1'b0),
    .NUM_VALUES(NUM_VALUES),
    .INIT_DELAY(INIT_DELAY),
    .SEED      (16'hACE1)
  ) u_src0 (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .rate        (src_rate),
    .inject_fault(inject_fault),
    .valid       (src_valid[0]),
    .data        (src_data0),
    .ready       (src_ready[0])
  );

  flow_pattern_source #(
    .SRC_ID    (1'b1),
    .NUM_VALUES(NUM_VALUES),
    .INIT_DELAY(INIT_DELAY),
    .SEED      (16'h5A3C)        // Distinct seed so the sources do not move in lockstep
  ) u_src1 (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .rate        (src_rate),
    .inject_fault(1'b0),
    .valid       (src_valid[1]),
    .data        (src_data1),
    .ready       (src_ready[1])
  );

  flow_rr_arbiter u_arb (
    .clk      (clk),
    .rst      (rst),
    .req_valid(src_valid),
    .req_data0(src_data0),
    .req_data1(src_data1),
    .req_ready(src_ready),
    .bus_valid(bus_valid),
    .bus_data (bus_data),
    .bus_ready(bus_ready)
  );

  flow_check_sink #(
    .NUM_VALUES(NUM_VALUES),
    .INIT_DELAY(INIT_DELAY),
    .SEED      (16'h1D87)
  ) u_sink (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .rate     (sink_rate),
    .bus_valid(bus_valid),
    .bus_data (bus_data),
    .bus_ready(bus_ready),
    .done     (done),
    .error    (error),
    .err_count(err_count),
    .bad_word (bad_word)
  );

endmodule

/* rtl/flow_check_sink.sv */
`timescale 1ns/1ps

module flow_check_sink #(
  parameter int                   NUM_VALUES = 64,
  parameter int                   INIT_DELAY = 10,
  parameter flow_bist_pkg::lfsr_t SEED       = 16'h1D87
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        start,
  input  flow_bist_pkg::rate_t        rate,
  input  logic                        bus_valid,
  input  flow_bist_pkg::flow_word_t   bus_data,
  output logic                        bus_ready,
  output logic                        done,       // All sources delivered NUM_VALUES
  output logic                        error,      // Sticky
  output flow_bist_pkg::err_count_t   err_count,  // Saturating count of bad words
  output flow_bist_pkg::flow_word_t   bad_word    // First bad word seen
);
  import flow_bist_pkg::*;

  seq_t               exp_seq [NUM_SRC];  // Expected next sequence per source
  logic [NUM_SRC-1:0] fin;                // Source has delivered everything
  src_id_t            rx_id;
  flow_word_t         exp_word;
  logic               xfer;
  logic               bad;

  // Ready may rise on its own and holds until a word arrives
  lfsr_rate_gate #(
    .INIT_DELAY(INIT_DELAY),
    .SEED      (SEED)
  ) u_gate (
    .clk  (clk),
    .rst  (rst),
    .start(start),
    .rate (rate),
    .ack  (bus_valid),
    .drive(bus_ready)
  );

  always_comb begin
    for (int i = 0; i < NUM_SRC; i++)
      fin[i] = (exp_seq[i] == seq_t'(NUM_VALUES));
  end

  assign rx_id    = word_id(bus_data);
  assign exp_word = make_word(rx_id, exp_seq[rx_id]);  // Pad bits must be zero too
  assign xfer     = bus_valid && bus_ready;
  assign bad      = fin[rx_id] || (bus_data != exp_word);  // Extra word or mismatch
  assign done     = &fin;                                  // One cycle after last transfer

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_SRC; i++)
        exp_seq[i] <= '0;
      error     <= 1'b0;
      err_count <= '0;
      bad_word  <= '0;
    end else if (xfer) begin
      // Advance even on a bad word so one fault does not cascade
      if (!fin[rx_id]) exp_seq[rx_id] <= exp_seq[rx_id] + 1'b1;

      if (bad) begin
        error <= 1'b1;
        if (err_count != '1) err_count <= err_count + 1'b1;
        if (!error) bad_word <= bus_data;  // Keep the first one only
      end
    end
  end

endmodule

/* rtl/flow_pattern_source.sv */
`timescale 1ns/1ps

module flow_pattern_source #(
  parameter flow_bist_pkg::src_id_t SRC_ID     = '0,
  parameter int                     NUM_VALUES = 64,
  parameter int                     INIT_DELAY = 10,
  parameter flow_bist_pkg::lfsr_t   SEED       = 16'hACE1
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      start,
  input  flow_bist_pkg::rate_t      rate,
  input  logic                      inject_fault,  // Pulse, corrupts the next word
  output logic                      valid,
  output flow_bist_pkg::flow_word_t data,
  input  logic                      ready
);
  import flow_bist_pkg::*;

  src_state_t state;
  seq_t       seq;         // Sequence of the word on offer, also words sent
  rate_t      gate_rate;
  logic       xfer;
  logic       last;        // Word on offer is the final one
  logic       fault_pend;  // Fault waiting for a word
  logic       held;        // Word was offered and stalled last cycle
  logic       held_flip;   // Flip state frozen with a stalled word
  logic       flip;        // Flip sequence bit 0 of the word on offer

  // Gate only runs while sending, zero rate keeps it quiet otherwise
  assign gate_rate = (state == SRC_RUN) ? rate : '0;

  lfsr_rate_gate #(
    .INIT_DELAY(INIT_DELAY),
    .SEED      (SEED)
  ) u_gate (
    .clk  (clk),
    .rst  (rst),
    .start(start),
    .rate (gate_rate),
    .ack  (ready),
    .drive(valid)
  );

  assign xfer = valid && ready;
  assign last = (seq == seq_t'(NUM_VALUES - 1));

  // A stalled word keeps its flip so the data stays stable
  assign flip = held ? held_flip : fault_pend;
  assign data = make_word(SRC_ID, seq ^ seq_t'(flip));

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= SRC_IDLE;
      seq   <= '0;
    end else begin
      case (state)
        SRC_IDLE: if (start) state <= SRC_RUN;
        SRC_RUN: begin
          if (xfer) begin
            seq <= seq + 1'b1;               // Never skips, only moves on transfer
            if (last) state <= SRC_DONE;
          end
        end
        default: state <= state;             // SRC_DONE is terminal until reset
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fault_pend <= 1'b0;
      held       <= 1'b0;
      held_flip  <= 1'b0;
    end else begin
      held <= valid && !ready;
      if (valid && !ready) held_flip <= flip;

      if (inject_fault)
        fault_pend <= 1'b1;       // New fault wins over a clear in the same cycle
      else if (xfer && flip)
        fault_pend <= 1'b0;       // Corrupted word has left
    end
  end

endmodule

/* rtl/flow_rr_arbiter.sv */
`timescale 1ns/1ps

module flow_rr_arbiter (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [1:0]                req_valid,
  input  flow_bist_pkg::flow_word_t req_data0,
  input  flow_bist_pkg::flow_word_t req_data1,
  output logic [1:0]                req_ready,
  output logic                      bus_valid,
  output flow_bist_pkg::flow_word_t bus_data,
  input  logic                      bus_ready
);
  import flow_bist_pkg::*;

  src_id_t prio;      // Requester with priority this round
  src_id_t gnt;       // Current grant
  src_id_t lock_gnt;  // Grant held over a stall
  logic    locked;    // Bus stalled last cycle
  logic    xfer;

  // Grant, locked while a word is stalled on the bus
  always_comb begin
    if (locked)
      gnt = lock_gnt;
    else if (req_valid[prio])
      gnt = prio;
    else if (req_valid[~prio])
      gnt = ~prio;
    else
      gnt = prio;       // Nobody asking, park on priority
  end

  // Combinational path, no added latency
  assign bus_valid = req_valid[gnt];
  assign bus_data  = (gnt == 1'b1) ? req_data1 : req_data0;
  assign xfer      = bus_valid && bus_ready;

  // Ready goes to the granted source only
  always_comb begin
    req_ready      = '0;
    req_ready[gnt] = bus_ready;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      prio     <= '0;
      locked   <= 1'b0;
      lock_gnt <= '0;
    end else begin
      locked   <= bus_valid && !bus_ready;
      lock_gnt <= gnt;
      if (xfer) prio <= ~gnt;  // Move past the winner
    end
  end

endmodule

/* rtl/lfsr_rate_gate.sv */
`timescale 1ns/1ps

module lfsr_rate_gate #(
  parameter int                   INIT_DELAY = 10,       // Idle cycles after start
  parameter flow_bist_pkg::lfsr_t SEED       = 16'hACE1  // Must be non-zero
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,  // Pulse, arms the gate
  input  flow_bist_pkg::rate_t rate,   // Threshold for the random draw
  input  logic                 ack,    // Other side of the handshake
  output logic                 drive   // Owner's valid or ready
);
  import flow_bist_pkg::*;

  localparam int DLY_W = $clog2(INIT_DELAY + 2);

  lfsr_t            lfsr;       // Fibonacci LFSR state
  logic             feedback;
  logic             active;     // Set by start, stays until reset
  logic [DLY_W-1:0] delay_cnt;  // Remaining initial delay
  logic             draw_hit;   // Random byte below threshold on an idle cycle

  // Taps for x^16 + x^14 + x^13 + x^11 + 1, maximal length
  assign feedback = lfsr[LFSR_W-1] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

  // Only draw when armed, past the delay and not already driving
  // A rate of zero can never win the compare
  assign draw_hit = active && (delay_cnt == '0) && !drive && (rate_t'(lfsr) < rate);

  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr      <= SEED;
      active    <= 1'b0;
      delay_cnt <= '0;
      drive     <= 1'b0;
    end else begin
      if (start) begin
        active    <= 1'b1;
        delay_cnt <= DLY_W'(INIT_DELAY);  // Hold off for INIT_DELAY cycles
      end else if (active && (delay_cnt != '0)) begin
        delay_cnt <= delay_cnt - 1'b1;
      end

      if (active)
        lfsr <= {lfsr[LFSR_W-2:0], feedback};  // Step once per cycle after start

      if (drive && ack)
        drive <= 1'b0;   // Transfer done, drop
      else if (draw_hit)
        drive <= 1'b1;   // Rise and hold until ack
    end
  end

endmodule

/* sim.f */
rtl/flow_bist_pkg.sv
rtl/lfsr_rate_gate.sv
rtl/flow_pattern_source.sv
rtl/flow_rr_arbiter.sv
rtl/flow_check_sink.sv
rtl/flow_bist_top.sv
verif/flow_bist_assertions.sv
verif/flow_bist_tb.sv

/* verif/flow_bist_assertions.sv */
`timescale 1ns/1ps

module flow_bist_assertions (
  input logic                      clk,
  input logic                      rst,
  input logic                      bus_valid,
  input logic                      bus_ready,
  input flow_bist_pkg::flow_word_t bus_data,
  input logic [1:0]                req_ready
);
  import flow_bist_pkg::*;

  // A stalled word stays put on the bus
  a_data_stable: assert property (@(posedge clk) disable iff (rst)
    bus_valid && !bus_ready |=> $stable(bus_data))
    else $error("bus_data changed while the bus was stalled");

  // Valid holds until the word is taken
  a_valid_hold: assert property (@(posedge clk) disable iff (rst)
    bus_valid && !bus_ready |=> bus_valid)
    else $error("bus_valid dropped before a transfer");

  // A transfer readies only the source whose word is on the bus
  a_one_ready: assert property (@(posedge clk) disable iff (rst)
    bus_valid && bus_ready |-> req_ready == (2'b01 << word_id(bus_data)))
    else $error("req_ready does not match the id of the word on the bus");

endmodule

bind flow_rr_arbiter flow_bist_assertions u_assertions (
  .clk      (clk),
  .rst      (rst),
  .bus_valid(bus_valid),
  .bus_ready(bus_ready),
  .bus_data (bus_data),
  .req_ready(req_ready)
);

/* verif/flow_bist_tb.sv */
`timescale 1ns/1ps

module flow_bist_tb;
  import flow_bist_pkg::*;

  localparam int     NUM_VALUES = 64;
  localparam int     INIT_DELAY = 10;
  localparam int     NUM_RUNS   = 6;
  // Worst case per run: every word of both sources waits a full 256-cycle draw
  localparam longint TIMEOUT_NS = 64'(NUM_RUNS) * NUM_VALUES * 2 * 256 * 8 + 200_000;

  logic       clk = 1'b0;
  logic       rst;
  logic       start;
  rate_t      src_rate;
  rate_t      sink_rate;
  logic       inject_fault;
  logic       done;
  logic       error;
  err_count_t err_count;
  flow_word_t bad_word;

  // Reference model
  logic       model_on;     // Off during reset
  int         sent0;        // Words delivered by source 0
  int         sent1;        // Words delivered by source 1
  logic       fault_pend;   // Fault waiting for its word
  int         fault_seq;    // Source-0 sequence that carries the fault
  logic       m_error;
  err_count_t m_err_count;
  flow_word_t m_bad_word;
  int         k;            // Fault pulses in the multi-fault run

  always #4 clk = ~clk;     // 8 ns period

  flow_bist_top #(
    .NUM_VALUES(NUM_VALUES),
    .INIT_DELAY(INIT_DELAY)
  ) UUT (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .src_rate    (src_rate),
    .sink_rate   (sink_rate),
    .inject_fault(inject_fault),
    .done        (done),
    .error       (error),
    .err_count   (err_count),
    .bad_word    (bad_word)
  );

  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %0t %s exp=%b act=%b", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input err_count_t exp, input err_count_t act);
    if (act !== exp) begin
      $display("ERR %0t %s exp=%0d act=%0d", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_word(input string name, input flow_word_t exp, input flow_word_t act);
    if (act !== exp) begin
      $display("ERR %0t %s exp=%h act=%h", $time, name, exp, act);
      abort_run();
    end
  endtask

  function automatic rate_t rand_rate(input int lo, input int hi);
    return rate_t'($urandom_range(hi, lo));
  endfunction

  // Model update on a bad word, sticky error and first-word capture
  task automatic note_bad(input flow_word_t word);
    if (!m_error) m_bad_word = word;
    m_error = 1'b1;
    if (m_err_count != '1) m_err_count = m_err_count + 1'b1;
  endtask

  // Compare at the falling edge, then book the transfers of this cycle
  always @(negedge clk) begin
    if (model_on) begin
      check_flag("done", (sent0 == NUM_VALUES) && (sent1 == NUM_VALUES), done);
      check_flag("error", m_error, error);
      check_count("err_count", m_err_count, err_count);
      check_word("bad_word", m_bad_word, bad_word);
      if (UUT.src_valid[0] && UUT.src_ready[0]) begin
        if (sent0 >= NUM_VALUES) begin
          $display("Source 0 delivered more than %0d words", NUM_VALUES);
          abort_run();
        end
        if (fault_pend && (sent0 == fault_seq)) begin
          note_bad({1'b0, 3'b000, seq_t'(sent0) ^ seq_t'(1)});  // Id 0, bit 0 flipped
          fault_pend = 1'b0;
        end
        sent0++;
      end
      if (UUT.src_valid[1] && UUT.src_ready[1]) begin
        if (sent1 >= NUM_VALUES) begin
          $display("Source 1 delivered more than %0d words", NUM_VALUES);
          abort_run();
        end
        sent1++;
      end
      // A word already on offer stays as is, so the fault lands on the one after it
      if (inject_fault && !fault_pend) begin
        fault_pend = 1'b1;
        fault_seq  = sent0 + ((UUT.src_valid[0] && !UUT.src_ready[0]) ? 1 : 0);
      end
    end
  end

  task automatic reset_dut();
    @(posedge clk);
    rst          <= 1'b1;
    start        <= 1'b0;
    inject_fault <= 1'b0;
    model_on      = 1'b0;
    repeat (8) @(posedge clk);
    rst         <= 1'b0;
    sent0        = 0;
    sent1        = 0;
    fault_pend   = 1'b0;
    fault_seq    = 0;
    m_error      = 1'b0;
    m_err_count  = '0;
    m_bad_word   = '0;
    model_on     = 1'b1;
    @(negedge clk);
    check_flag("done", 1'b0, done);    // Everything cleared by reset
    check_flag("error", 1'b0, error);
    check_count("err_count", '0, err_count);
    check_word("bad_word", '0, bad_word);
  endtask

  task automatic start_run(input rate_t s_rate, input rate_t k_rate);
    @(posedge clk);
    src_rate  <= s_rate;
    sink_rate <= k_rate;
    start     <= 1'b1;
    @(posedge clk);
    start     <= 1'b0;
  endtask

  task automatic pulse_inject();
    @(posedge clk);
    inject_fault <= 1'b1;
    @(posedge clk);
    inject_fault <= 1'b0;
  endtask

  task automatic wait_done();
    @(negedge clk);
    while (done !== 1'b1) @(negedge clk);  // Watchdog catches a hang
  endtask

  task automatic check_end(input logic exp_err, input err_count_t exp_cnt,
                           input flow_word_t exp_word);
    check_flag("done", 1'b1, done);
    check_flag("error", exp_err, error);
    check_count("err_count", exp_cnt, err_count);
    check_word("bad_word", exp_word, bad_word);
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns, a run hung without done", TIMEOUT_NS);
    abort_run();
  end

  initial begin
    void'($urandom(32'h610988d5));
    rst          = 1'b1;
    start        = 1'b0;
    src_rate     = '0;
    sink_rate    = '0;
    inject_fault = 1'b0;
    model_on     = 1'b0;

    repeat (2) begin                          // Clean runs
      reset_dut();
      start_run(rand_rate(32, 255), rand_rate(32, 255));
      wait_done();
      check_end(1'b0, '0, '0);
    end

    reset_dut();                              // Heavy back-pressure from the sink
    start_run(rand_rate(192, 255), rand_rate(1, 16));
    wait_done();
    check_end(1'b0, '0, '0);

    reset_dut();                              // One fault early in the run
    start_run(rand_rate(64, 255), rand_rate(64, 255));
    repeat (INIT_DELAY + $urandom_range(NUM_VALUES / 2, 0)) @(posedge clk);
    pulse_inject();
    wait_done();
    check_end(1'b1, 16'd1, m_bad_word);

    reset_dut();                              // Several faults, one word each
    start_run(rand_rate(64, 255), rand_rate(64, 255));
    k = $urandom_range(4, 2);
    repeat (INIT_DELAY) @(posedge clk);
    repeat (k) begin
      repeat ($urandom_range(4, 1)) @(posedge clk);
      pulse_inject();
      while (fault_pend && (sent0 < NUM_VALUES)) @(posedge clk);  // Let it land first
    end
    wait_done();
    check_end(1'b1, err_count_t'(k), m_bad_word);

    reset_dut();                              // Reset clears the faulty run
    start_run(rand_rate(32, 255), rand_rate(32, 255));
    wait_done();
    check_end(1'b0, '0, '0);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
